/* compile.f */
+incdir+logic
logic/cpu_types_pkg.sv
logic/alu.sv
logic/control_unit.sv
logic/register_file.sv
logic/program_counter.sv
logic/datapath.sv
testbench/datapath_checker.sv
testbench/tb_datapath.sv

/* logic/alu.sv */
/*
  alu
  combinational arithmetic, logic, compare and shift unit
  with a zero flag for branch compare
*/

`timescale 1ns/1ps
`default_nettype none

module alu (
  input  cpu_types_pkg::word_t   port_a,
  input  cpu_types_pkg::word_t   port_b,
  input  logic [4:0]             shamt,
  input  cpu_types_pkg::alu_op_t op,
  output cpu_types_pkg::word_t   result,
  output logic                   zero
);
  import cpu_types_pkg::*;

  always_comb begin
    unique case (op)
      ALU_ADD:  result = port_a + port_b;
      ALU_SUB:  result = port_a - port_b;
      ALU_AND:  result = port_a & port_b;
      ALU_OR:   result = port_a | port_b;
      ALU_XOR:  result = port_a ^ port_b;
      ALU_NOR:  result = ~(port_a | port_b);
      // signed compare
      ALU_SLT:  result = word_t'($signed(port_a) < $signed(port_b));
      ALU_SLTU: result = word_t'(port_a < port_b);
      // shifts act on rt, amount from the shamt field
      ALU_SLL:  result = port_b << shamt;
      ALU_SRL:  result = port_b >> shamt;
      // upper half from the immediate
      ALU_LUI:  result = {port_b[15:0], 16'h0000};
      default:  result = '0;
    endcase
  end

  // beq/bne compare through SUB
  assign zero = (result == '0);

endmodule

`default_nettype wire

/* logic/control_unit.sv */
/*
  control unit
  decodes opcode and funct into the control word
  unknown encodings decode as a no-op
*/

`timescale 1ns/1ps
`default_nettype none

module control_unit (
  input  cpu_types_pkg::word_t instr,
  output cpu_types_pkg::ctrl_t ctrl
);
  import cpu_types_pkg::*;

  opcode_t opcode;
  funct_t  funct;

  assign opcode = opcode_t'(instr[31:26]);
  assign funct  = funct_t'(instr[5:0]);

  always_comb begin
    // everything off unless set below
    ctrl        = '0;
    ctrl.alu_op = ALU_ADD;

    case (opcode)
      // --------------------------------------------------
      // register ops
      // --------------------------------------------------
      RTYPE: begin
        ctrl.reg_dst_rd = 1'b1;
        ctrl.reg_wr     = 1'b1;
        case (funct)
          ADDU: ctrl.alu_op = ALU_ADD;
          SUBU: ctrl.alu_op = ALU_SUB;
          AND:  ctrl.alu_op = ALU_AND;
          OR:   ctrl.alu_op = ALU_OR;
          XOR:  ctrl.alu_op = ALU_XOR;
          NOR:  ctrl.alu_op = ALU_NOR;
          SLT:  ctrl.alu_op = ALU_SLT;
          SLTU: ctrl.alu_op = ALU_SLTU;
          SLL:  ctrl.alu_op = ALU_SLL;
          SRL:  ctrl.alu_op = ALU_SRL;
          JR: begin
            // rt is r0 in the encoding, so rs | 0 passes rs to the pc
            ctrl.alu_op = ALU_OR;
            ctrl.reg_wr = 1'b0;
            ctrl.jr     = 1'b1;
          end
          default: ctrl.reg_wr = 1'b0;
        endcase
      end

      // --------------------------------------------------
      // immediate ops
      // --------------------------------------------------
      ADDIU, SLTI: begin
        ctrl.alu_op      = (opcode == SLTI) ? ALU_SLT : ALU_ADD;
        ctrl.alu_src_imm = 1'b1;
        ctrl.sign_ext    = 1'b1;
        ctrl.reg_wr      = 1'b1;
      end
      ANDI, ORI, XORI: begin
        // logical immediates are zero extended
        ctrl.alu_op      = (opcode == ANDI) ? ALU_AND :
                           (opcode == ORI)  ? ALU_OR  : ALU_XOR;
        ctrl.alu_src_imm = 1'b1;
        ctrl.reg_wr      = 1'b1;
      end
      LUI: begin
        ctrl.alu_op      = ALU_LUI;
        ctrl.alu_src_imm = 1'b1;
        ctrl.reg_wr      = 1'b1;
        ctrl.lui         = 1'b1;
      end

      // memory, address is rs + sext(imm)
      LW: begin
        ctrl.alu_src_imm = 1'b1;
        ctrl.sign_ext    = 1'b1;
        ctrl.reg_wr      = 1'b1;
        ctrl.mem_rd      = 1'b1;
        ctrl.mem_to_reg  = 1'b1;
      end
      SW: begin
        ctrl.alu_src_imm = 1'b1;
        ctrl.sign_ext    = 1'b1;
        ctrl.mem_wr      = 1'b1;
      end

      // --------------------------------------------------
      // control flow
      // --------------------------------------------------
      BEQ: begin
        ctrl.alu_op   = ALU_SUB;
        ctrl.sign_ext = 1'b1;
        ctrl.beq      = 1'b1;
      end
      BNE: begin
        ctrl.alu_op   = ALU_SUB;
        ctrl.sign_ext = 1'b1;
        ctrl.bne      = 1'b1;
      end
      J:   ctrl.jump = 1'b1;
      // link into r31, chosen in execute
      JAL: begin
        ctrl.jal    = 1'b1;
        ctrl.reg_wr = 1'b1;
      end
      HALT: ctrl.halt = 1'b1;
      default: ctrl = '0;
    endcase
  end

endmodule

`default_nettype wire

/* logic/cpu_cfg.svh */
/*
  cpu core configuration
  reset pc, word width and register count for the pipelined core
*/

`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// pc loaded on reset
`define CPU_PC_INIT 32'h0000_0000

// data and address width
`define CPU_WORD_W 32

// architectural register count, r0 hardwired to zero
`define CPU_REG_N 32

`endif

/* logic/cpu_types_pkg.sv */
/*
  cpu types package
  opcode, funct and alu op encodings, decoded control word,
  memory bus request structs and the four stage latches
*/

`default_nettype none

`include "cpu_cfg.svh"

package cpu_types_pkg;

  typedef logic [`CPU_WORD_W-1:0] word_t;

  // --------------------------------------------------
  // encodings
  // --------------------------------------------------
  typedef enum logic [5:0] {
    RTYPE = 6'h00,
    J     = 6'h02,
    JAL   = 6'h03,
    BEQ   = 6'h04,
    BNE   = 6'h05,
    ADDIU = 6'h09,
    SLTI  = 6'h0A,
    ANDI  = 6'h0C,
    ORI   = 6'h0D,
    XORI  = 6'h0E,
    LUI   = 6'h0F,
    LW    = 6'h23,
    SW    = 6'h2B,
    HALT  = 6'h3F
  } opcode_t;

  typedef enum logic [5:0] {
    SLL  = 6'h00,
    SRL  = 6'h02,
    JR   = 6'h08,
    ADDU = 6'h21,
    SUBU = 6'h23,
    AND  = 6'h24,
    OR   = 6'h25,
    XOR  = 6'h26,
    NOR  = 6'h27,
    SLT  = 6'h2A,
    SLTU = 6'h2B
  } funct_t;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
    ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_LUI
  } alu_op_t;

  // decoded control word
  typedef struct packed {
    alu_op_t alu_op;
    logic    alu_src_imm;
    logic    sign_ext;
    logic    reg_dst_rd;
    logic    reg_wr;
    logic    mem_rd;
    logic    mem_wr;
    logic    mem_to_reg;
    logic    beq;
    logic    bne;
    logic    jump;
    logic    jal;
    logic    jr;
    logic    lui;
    logic    halt;
  } ctrl_t;

  // --------------------------------------------------
  // memory buses
  // --------------------------------------------------
  typedef struct packed {
    logic  ren;
    word_t addr;
  } imem_req_t;

  typedef struct packed {
    logic  ren;
    logic  wen;
    word_t addr;
    word_t store;
  } dmem_req_t;

  // --------------------------------------------------
  // stage latches
  // --------------------------------------------------
  typedef struct packed {
    logic  valid;
    word_t instr;
    word_t pc_plus4;
  } if_id_t;

  typedef struct packed {
    logic       valid;
    ctrl_t      ctrl;
    word_t      instr;
    word_t      pc_plus4;
    word_t      rdat1;
    word_t      rdat2;
    word_t      imm_ext;
    logic [4:0] shamt;
  } id_ex_t;

  typedef struct packed {
    logic       valid;
    ctrl_t      ctrl;
    word_t      instr;
    word_t      pc_plus4;
    word_t      alu_out;
    logic       zero;
    word_t      store_data;
    logic [4:0] wsel;
  } ex_mem_t;

  typedef struct packed {
    logic        valid;
    ctrl_t       ctrl;
    word_t       pc_plus4;
    word_t       alu_out;
    word_t       load_data;
    logic [15:0] imm;
    logic [4:0]  wsel;
  } mem_wb_t;

endpackage

`default_nettype wire

/* logic/datapath.sv */
/*
  datapath
  five-stage core top: stage latches, decode extender,
  execute muxes, writeback mux, stall enable and sticky halt.
  no forwarding or flush; branch/jump resolve in memory stage
*/

`timescale 1ns/1ps
`default_nettype none

module datapath (
  input  logic                     CLK,
  input  logic                     nRST,
  output cpu_types_pkg::imem_req_t imem_req,
  input  cpu_types_pkg::word_t     imem_load,
  input  logic                     ihit,
  output cpu_types_pkg::dmem_req_t dmem_req,
  input  cpu_types_pkg::word_t     dmem_load,
  input  logic                     dhit,
  output logic                     halt
);
  import cpu_types_pkg::*;

  // stage latches
  if_id_t  if_id;
  id_ex_t  id_ex;
  ex_mem_t ex_mem;
  mem_wb_t mem_wb;

  logic       advance;
  logic       dreq_raw;
  logic       dmem_done;
  word_t      load_hold;
  word_t      load_data;
  word_t      pc;
  ctrl_t      ctrl_dec;
  word_t      rdat1;
  word_t      rdat2;
  word_t      imm_ext;
  word_t      alu_b;
  word_t      alu_out;
  logic       alu_zero;
  logic [4:0] wsel_ex;
  logic       rf_wen;
  word_t      rf_wdat;

  // --------------------------------------------------
  // stall rule and memory strobes
  // --------------------------------------------------
  assign dreq_raw = ex_mem.valid && (ex_mem.ctrl.mem_rd || ex_mem.ctrl.mem_wr);

  // drop the strobe once served but still stalled on ihit,
  // so a store is not written twice
  assign dmem_req.ren   = ex_mem.valid && ex_mem.ctrl.mem_rd && !dmem_done;
  assign dmem_req.wen   = ex_mem.valid && ex_mem.ctrl.mem_wr && !dmem_done;
  assign dmem_req.addr  = ex_mem.alu_out;
  assign dmem_req.store = ex_mem.store_data;

  assign imem_req.ren  = !halt;
  assign imem_req.addr = pc;

  // everything moves together or nothing moves
  assign advance = ihit && (!(dmem_req.ren || dmem_req.wen) || dhit) && !halt;

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST)
      dmem_done <= 1'b0;
    else if (advance)
      dmem_done <= 1'b0;
    else if (dreq_raw && dhit)
      dmem_done <= 1'b1;
  end

  // load word kept while waiting on fetch
  always_ff @(posedge CLK) begin
    if (dmem_req.ren && dhit)
      load_hold <= dmem_load;
  end

  assign load_data = dmem_done ? load_hold : dmem_load;

  // --------------------------------------------------
  // fetch
  // --------------------------------------------------
  program_counter PC (
    .CLK    (CLK),
    .nRST   (nRST),
    .en     (advance),
    .ex_mem (ex_mem),
    .pc     (pc)
  );

  // --------------------------------------------------
  // decode
  // --------------------------------------------------
  control_unit CU (
    .instr (if_id.instr),
    .ctrl  (ctrl_dec)
  );

  register_file RF (
    .CLK   (CLK),
    .nRST  (nRST),
    .wen   (rf_wen),
    .wsel  (mem_wb.wsel),
    .rsel1 (if_id.instr[25:21]),
    .rsel2 (if_id.instr[20:16]),
    .wdat  (rf_wdat),
    .rdat1 (rdat1),
    .rdat2 (rdat2)
  );

  // sign or zero extend
  assign imm_ext = ctrl_dec.sign_ext ? {{16{if_id.instr[15]}}, if_id.instr[15:0]}
                                     : {16'h0000, if_id.instr[15:0]};

  // --------------------------------------------------
  // execute
  // --------------------------------------------------
  assign alu_b = id_ex.ctrl.alu_src_imm ? id_ex.imm_ext : id_ex.rdat2;

  alu ALU (
    .port_a (id_ex.rdat1),
    .port_b (alu_b),
    .shamt  (id_ex.shamt),
    .op     (id_ex.ctrl.alu_op),
    .result (alu_out),
    .zero   (alu_zero)
  );

  // dest reg: r31 for jal, rd for R-type, else rt
  assign wsel_ex = id_ex.ctrl.jal        ? 5'd31 :
                   id_ex.ctrl.reg_dst_rd ? id_ex.instr[15:11] : id_ex.instr[20:16];

  // --------------------------------------------------
  // writeback
  // --------------------------------------------------
  always_comb begin
    if (mem_wb.ctrl.lui)
      rf_wdat = {mem_wb.imm, 16'h0000};
    else if (mem_wb.ctrl.jal)
      rf_wdat = mem_wb.pc_plus4;
    else if (mem_wb.ctrl.mem_to_reg)
      rf_wdat = mem_wb.load_data;
    else
      rf_wdat = mem_wb.alu_out;
  end

  // write lands on the edge the instruction leaves writeback
  assign rf_wen = advance && mem_wb.valid && mem_wb.ctrl.reg_wr;

  // --------------------------------------------------
  // stage latches
  // --------------------------------------------------
  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      if_id  <= '0;
      id_ex  <= '0;
      ex_mem <= '0;
      mem_wb <= '0;
    end else if (advance) begin
      // fetch -> decode
      if_id.valid    <= 1'b1;
      if_id.instr    <= imem_load;
      if_id.pc_plus4 <= pc + 32'd4;

      // decode -> execute, bubble keeps a zero control word
      id_ex.valid    <= if_id.valid;
      id_ex.ctrl     <= if_id.valid ? ctrl_dec : '0;
      id_ex.instr    <= if_id.instr;
      id_ex.pc_plus4 <= if_id.pc_plus4;
      id_ex.rdat1    <= rdat1;
      id_ex.rdat2    <= rdat2;
      id_ex.imm_ext  <= imm_ext;
      id_ex.shamt    <= if_id.instr[10:6];

      // execute -> memory
      ex_mem.valid      <= id_ex.valid;
      ex_mem.ctrl       <= id_ex.ctrl;
      ex_mem.instr      <= id_ex.instr;
      ex_mem.pc_plus4   <= id_ex.pc_plus4;
      ex_mem.alu_out    <= alu_out;
      ex_mem.zero       <= alu_zero;
      ex_mem.store_data <= id_ex.rdat2;
      ex_mem.wsel       <= wsel_ex;

      // memory -> writeback
      mem_wb.valid     <= ex_mem.valid;
      mem_wb.ctrl      <= ex_mem.ctrl;
      mem_wb.pc_plus4  <= ex_mem.pc_plus4;
      mem_wb.alu_out   <= ex_mem.alu_out;
      mem_wb.load_data <= load_data;
      mem_wb.imm       <= ex_mem.instr[15:0];
      mem_wb.wsel      <= ex_mem.wsel;
    end
  end

  // sticky halt, set as HALT leaves the memory stage
  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST)
      halt <= 1'b0;
    else if (advance && ex_mem.valid && ex_mem.ctrl.halt)
      halt <= 1'b1;
  end

endmodule

`default_nettype wire

/* logic/program_counter.sv */
/*
  program counter
  pc register and next-pc select; branches and jumps
  resolve from the memory-stage latch
*/

`timescale 1ns/1ps
`default_nettype none

`include "cpu_cfg.svh"

module program_counter (
  input  logic                   CLK,
  input  logic                   nRST,
  input  logic                   en,
  input  cpu_types_pkg::ex_mem_t ex_mem,
  output cpu_types_pkg::word_t   pc
);
  import cpu_types_pkg::*;

  word_t pc_next;
  word_t br_offset;
  logic  br_taken;

  // word offset, sign extended and shifted by 2
  assign br_offset = {{14{ex_mem.instr[15]}}, ex_mem.instr[15:0], 2'b00};
  assign br_taken  = ex_mem.valid &&
                     ((ex_mem.ctrl.beq && ex_mem.zero) ||
                      (ex_mem.ctrl.bne && !ex_mem.zero));

  always_comb begin
    if (ex_mem.valid && (ex_mem.ctrl.jump || ex_mem.ctrl.jal))
      pc_next = {ex_mem.pc_plus4[31:28], ex_mem.instr[25:0], 2'b00};
    else if (ex_mem.valid && ex_mem.ctrl.jr)
      // rs passed through the alu
      pc_next = ex_mem.alu_out;
    else if (br_taken)
      pc_next = ex_mem.pc_plus4 + br_offset;
    else
      pc_next = pc + 32'd4;
  end

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST)
      pc <= `CPU_PC_INIT;
    else if (en)
      pc <= pc_next;
  end

endmodule

`default_nettype wire

/* logic/register_file.sv */
/*
  register file
  32 x 32 registers, r0 reads zero, clocked write,
  combinational reads with same-cycle write bypass
*/

`timescale 1ns/1ps
`default_nettype none

`include "cpu_cfg.svh"

module register_file (
  input  logic                 CLK,
  input  logic                 nRST,
  input  logic                 wen,
  input  logic [4:0]           wsel,
  input  logic [4:0]           rsel1,
  input  logic [4:0]           rsel2,
  input  cpu_types_pkg::word_t wdat,
  output cpu_types_pkg::word_t rdat1,
  output cpu_types_pkg::word_t rdat2
);
  import cpu_types_pkg::*;

  word_t regs [`CPU_REG_N];

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      for (int i = 0; i < `CPU_REG_N; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && (wsel != 5'd0)) begin
      regs[wsel] <= wdat;
    end
  end

  // writeback value seen by decode in the same cycle
  always_comb begin
    rdat1 = regs[rsel1];
    rdat2 = regs[rsel2];
    if (wen && (wsel != 5'd0) && (wsel == rsel1)) rdat1 = wdat;
    if (wen && (wsel != 5'd0) && (wsel == rsel2)) rdat2 = wdat;
  end

endmodule

`default_nettype wire

/* testbench/datapath_checker.sv */
/*
  datapath protocol checker
  bound to the core top; watches the memory strobes
  and the sticky halt on the datapath ports
*/

`timescale 1ns/1ps
`default_nettype none

module datapath_checker (
  input logic                     CLK,
  input logic                     nRST,
  input cpu_types_pkg::imem_req_t imem_req,
  input cpu_types_pkg::dmem_req_t dmem_req,
  input logic                     dhit,
  input logic                     halt
);
  import cpu_types_pkg::*;

  int unsigned fail_count = 0;
  logic        dreq;

  assign dreq = dmem_req.ren || dmem_req.wen;

  // --------------------------------------------------
  // reset
  // --------------------------------------------------
  // nothing can reach memory in the first three cycles
  reset_quiet: assert property (@(posedge CLK)
    $rose(nRST) |-> (!halt && !dreq) [*3])
    else begin
      fail_count++;
      $error("data strobe or halt active right after reset");
    end

  // --------------------------------------------------
  // data bus
  // --------------------------------------------------
  // waiting request holds strobe, address and data
  req_stable: assert property (@(posedge CLK) disable iff (!nRST)
    dreq && !dhit |=> $stable(dmem_req))
    else begin
      fail_count++;
      $error("data request changed before dhit");
    end

  rd_wr_exclusive: assert property (@(posedge CLK) disable iff (!nRST)
    !(dmem_req.ren && dmem_req.wen))
    else begin
      fail_count++;
      $error("ren and wen high together");
    end

  // --------------------------------------------------
  // halt
  // --------------------------------------------------
  halt_sticky: assert property (@(posedge CLK) disable iff (!nRST)
    halt |=> halt)
    else begin
      fail_count++;
      $error("halt dropped before reset");
    end

  // halted core is silent on both buses
  halt_quiet: assert property (@(posedge CLK) disable iff (!nRST)
    halt |-> !imem_req.ren && !dreq)
    else begin
      fail_count++;
      $error("memory request while halted");
    end

endmodule

bind datapath datapath_checker CHK (
  .CLK      (CLK),
  .nRST     (nRST),
  .imem_req (imem_req),
  .dmem_req (dmem_req),
  .dhit     (dhit),
  .halt     (halt)
);

`default_nettype wire

/* testbench/tb_datapath.sv */
/*
  testbench for the pipelined core
  instruction and data memories with random hit gaps,
  a fixed test program and a table of expected stores
*/

`timescale 1ns/1ps
`default_nettype none

module tb_datapath;
  import cpu_types_pkg::*;

  // about 75 instructions at a worst case near 8 cycles each, wide margin
  localparam int unsigned TIMEOUT = 4000;
  // r30 value, only wrong-path stores carry it
  localparam word_t POISON = 32'hDEAD_0000;

  logic      CLK;
  logic      nRST;
  imem_req_t imem_req;
  word_t     imem_load;
  logic      ihit;
  dmem_req_t dmem_req;
  word_t     dmem_load;
  logic      dhit;
  logic      halt;

  word_t       imem [128];
  word_t       dmem [128];
  // {addr, data} in program order
  logic [63:0] exp_q [$];
  int unsigned prog_len;
  int unsigned exp_total;
  int unsigned stores;
  int unsigned errors;
  int unsigned cycles;
  logic [15:0] lfsr;
  logic        dbusy;
  logic [1:0]  dleft;

  datapath DUT (
    .CLK       (CLK),
    .nRST      (nRST),
    .imem_req  (imem_req),
    .imem_load (imem_load),
    .ihit      (ihit),
    .dmem_req  (dmem_req),
    .dmem_load (dmem_load),
    .dhit      (dhit),
    .halt      (halt)
  );

  initial begin
    CLK = 1'b0;
    forever #10 CLK = ~CLK;
  end

  // --------------------------------------------------
  // helpers
  // --------------------------------------------------
  // galois step, x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic take_bit(output logic b);
    b    = lfsr[0];
    lfsr = lfsr_next(lfsr);
  endtask

  function automatic word_t r_format(input logic [5:0] funct, input logic [4:0] rs,
                                     input logic [4:0] rt, input logic [4:0] rd,
                                     input logic [4:0] sh);
    return {6'h00, rs, rt, rd, sh, funct};
  endfunction

  function automatic word_t i_format(input logic [5:0] op, input logic [4:0] rs,
                                     input logic [4:0] rt, input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  // target given as a word index
  function automatic word_t j_format(input logic [5:0] op, input logic [25:0] idx);
    return {op, idx};
  endfunction

  // preload pattern over the full byte address
  function automatic word_t fill_word(input word_t a);
    return a ^ 32'hC3C3_0000;
  endfunction

  task automatic emit(input word_t w);
    imem[prog_len] = w;
    prog_len++;
  endtask

  task automatic expect_store(input word_t a, input word_t d);
    exp_q.push_back({a, d});
    exp_total++;
  endtask

  task automatic check_store(input word_t addr, input word_t data);
    logic [63:0] exp;
    stores++;
    assert (data !== POISON) else begin
      errors++;
      $display("wrong-path store to address %h at %0t", addr, $time);
    end
    assert (exp_q.size() > 0) else begin
      errors++;
      $display("store to %h at %0t beyond the expected table", addr, $time);
    end
    if (exp_q.size() > 0) begin
      exp = exp_q.pop_front();
      assert (addr == exp[63:32]) else begin
        errors++;
        $display("Error at %0t: dmem_req.addr = %h, expected %h", $time, addr, exp[63:32]);
      end
      assert (data == exp[31:0]) else begin
        errors++;
        $display("Error at %0t: dmem_req.store = %h, expected %h", $time, data, exp[31:0]);
      end
    end
  endtask

  // --------------------------------------------------
  // test program
  // --------------------------------------------------
  task automatic load_program();
    // immediates
    emit(i_format(ADDIU, 0, 1, 16'h0123));
    emit(i_format(ADDIU, 0, 2, 16'hFFFB));
    emit(i_format(ORI, 0, 3, 16'hF0F0));
    emit(i_format(XORI, 0, 4, 16'h8001));
    emit(i_format(ANDI, 1, 5, 16'h00FF));
    // register ops, sources at least three back
    emit(r_format(ADDU, 1, 3, 6, 0));
    emit(r_format(SUBU, 1, 2, 7, 0));
    emit(r_format(AND, 3, 4, 8, 0));
    emit(r_format(OR, 3, 4, 9, 0));
    emit(r_format(XOR, 3, 4, 10, 0));
    emit(r_format(NOR, 1, 3, 11, 0));
    emit(r_format(SLT, 2, 1, 12, 0));
    emit(r_format(SLTU, 2, 1, 13, 0));
    emit(r_format(SLL, 0, 1, 14, 4));
    emit(r_format(SRL, 0, 2, 15, 8));
    emit(i_format(SLTI, 2, 16, 16'hFFFC));
    emit(i_format(LUI, 0, 17, 16'hBEEF));
    emit(i_format(LUI, 0, 30, 16'hDEAD));
    // results out, word 18
    for (int r = 5; r <= 17; r++) begin
      emit(i_format(SW, 0, 5'(r), 16'((r - 5) * 4)));
    end
    // loads, a stored word and a preloaded one
    emit(i_format(LW, 0, 18, 16'h0004));
    emit(i_format(LW, 0, 19, 16'h0100));
    emit(j_format(JAL, 37));
    emit(i_format(SW, 0, 18, 16'h0034));
    emit(i_format(SW, 0, 19, 16'h0038));
    emit(i_format(ADDIU, 0, 21, 16'h0011));
    // word 37, jal target
    emit(i_format(SW, 0, 31, 16'h003C));
    // taken beq to word 44
    emit(i_format(BEQ, 12, 16, 16'd5));
    emit(i_format(ADDIU, 0, 22, 16'h0022));
    emit(i_format(ADDIU, 0, 23, 16'h0033));
    emit(32'h0);
    emit(i_format(SW, 0, 30, 16'h0040));
    emit(i_format(SW, 0, 30, 16'h0040));
    emit(i_format(SW, 0, 21, 16'h0040));
    // untaken bne, then untaken beq
    emit(i_format(BNE, 12, 16, 16'd4));
    emit(32'h0);
    emit(32'h0);
    emit(32'h0);
    emit(i_format(SW, 0, 22, 16'h0044));
    emit(i_format(BEQ, 12, 13, 16'd4));
    emit(i_format(ADDIU, 0, 24, 16'h0044));
    emit(i_format(ADDIU, 0, 26, 16'h0120));
    emit(32'h0);
    emit(i_format(SW, 0, 23, 16'h0048));
    // taken bne to word 60
    emit(i_format(BNE, 12, 13, 16'd4));
    emit(i_format(ADDIU, 0, 25, 16'h0055));
    emit(32'h0);
    emit(32'h0);
    emit(i_format(SW, 0, 30, 16'h004C));
    emit(i_format(SW, 0, 24, 16'h004C));
    // j to word 66
    emit(j_format(J, 66));
    emit(32'h0);
    emit(32'h0);
    emit(32'h0);
    emit(i_format(SW, 0, 30, 16'h0050));
    emit(i_format(SW, 0, 25, 16'h0050));
    // jr to 0x120, word 72
    emit(r_format(JR, 26, 0, 0, 0));
    emit(i_format(ADDIU, 0, 27, 16'h0066));
    emit(32'h0);
    emit(32'h0);
    emit(i_format(SW, 0, 30, 16'h0054));
    emit(i_format(SW, 0, 27, 16'h0054));
    emit(j_format(HALT, 0));
  endtask

  // worked out by hand from the instruction rules
  task automatic load_expected();
    expect_store(32'h00, 32'h0000_0023);
    expect_store(32'h04, 32'h0000_F213);
    expect_store(32'h08, 32'h0000_0128);
    expect_store(32'h0C, 32'h0000_8000);
    expect_store(32'h10, 32'h0000_F0F1);
    expect_store(32'h14, 32'h0000_70F1);
    expect_store(32'h18, 32'hFFFF_0E0C);
    expect_store(32'h1C, 32'h0000_0001);
    expect_store(32'h20, 32'h0000_0000);
    expect_store(32'h24, 32'h0000_1230);
    expect_store(32'h28, 32'h00FF_FFFF);
    expect_store(32'h2C, 32'h0000_0001);
    expect_store(32'h30, 32'hBEEF_0000);
    expect_store(32'h34, 32'h0000_F213);
    expect_store(32'h38, fill_word(32'h100));
    // jal link, address of jal plus 4
    expect_store(32'h3C, 32'h0000_0088);
    expect_store(32'h40, 32'h0000_0011);
    expect_store(32'h44, 32'h0000_0022);
    expect_store(32'h48, 32'h0000_0033);
    expect_store(32'h4C, 32'h0000_0044);
    expect_store(32'h50, 32'h0000_0055);
    expect_store(32'h54, 32'h0000_0066);
  endtask

  // --------------------------------------------------
  // memory models
  // --------------------------------------------------
  always @(posedge CLK) begin
    logic       b0;
    logic       b1;
    logic [1:0] left;
    if (!nRST) begin
      ihit  <= 1'b0;
      dhit  <= 1'b0;
      dbusy <= 1'b0;
      dleft <= 2'd0;
    end else begin
      // pc may move on a hit edge, so skip a cycle before the next hit
      if (ihit) begin
        ihit <= 1'b0;
      end else begin
        take_bit(b0);
        ihit      <= b0 && imem_req.ren;
        imem_load <= imem[imem_req.addr[8:2]];
      end

      if (dhit) begin
        // served at this edge
        dhit  <= 1'b0;
        dbusy <= 1'b0;
        if (dmem_req.wen) begin
          check_store(dmem_req.addr, dmem_req.store);
          dmem[dmem_req.addr[8:2]] <= dmem_req.store;
        end
      end else if (dmem_req.ren || dmem_req.wen) begin
        // 0 to 3 extra wait cycles per request
        if (dbusy) begin
          left = dleft;
        end else begin
          take_bit(b0);
          take_bit(b1);
          left = {b1, b0};
        end
        dbusy <= 1'b1;
        dleft <= left - 2'd1;
        if (left == 2'd0) begin
          dhit      <= 1'b1;
          dmem_load <= dmem[dmem_req.addr[8:2]];
        end
      end
    end
  end

  // --------------------------------------------------
  // main sequence
  // --------------------------------------------------
  initial begin
    nRST      = 1'b0;
    ihit      = 1'b0;
    dhit      = 1'b0;
    imem_load = '0;
    dmem_load = '0;
    lfsr      = 16'd8;
    prog_len  = 0;
    exp_total = 0;
    stores    = 0;
    errors    = 0;
    cycles    = 0;
    for (int i = 0; i < 128; i++) begin
      imem[i] = '0;
      dmem[i] = fill_word(word_t'(i) << 2);
    end
    load_program();
    load_expected();

    repeat (3) @(posedge CLK);
    nRST <= 1'b1;

    while (halt !== 1'b1 && cycles < TIMEOUT) begin
      @(posedge CLK);
      cycles++;
    end
    if (halt !== 1'b1) begin
      errors++;
      $display("timeout, halt not seen within %0d cycles", TIMEOUT);
    end

    // halted core stays under the checker for a few cycles
    repeat (4) @(posedge CLK);
    assert (stores == exp_total) else begin
      errors++;
      $display("Error at %0t: store count = %0d, expected %0d", $time, stores, exp_total);
    end

    $display("store and program errors: %0d, protocol assertion failures: %0d",
             errors, DUT.CHK.fail_count);
    if (errors == 0 && DUT.CHK.fail_count == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
